//--- project.f
hw/core_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/front_end_top.sv
tests/front_end_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module front_end_tb -o front_end_sim

out=$(./obj_dir/front_end_sim)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- tests/front_end_tb.sv
// testbench for the front end with an instruction table of expected decode fields,
// register preload and a cycle-exact trace check on the ID/EX output
module front_end_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int rows           = 32;
    localparam int timeout_cycles = rows * 4 + 100;
    localparam int drive_delay    = 2;
    // rs of this row is written in the same cycle it is read
    localparam int bypass_row     = 23;
    // beq row that the back end resolves as taken
    localparam int redir_row      = 26;
    localparam int redir_addr     = 30;
    // jr at row 24 reads r9
    localparam int jr_reg         = 9;
    localparam int jr_target      = 26;

    logic      clk;
    logic      arst_n;
    logic      run;
    imem_wr_t  imem_wr;
    wb_t       wb;
    redirect_t redirect;
    logic      ex_valid;
    id_ex_t    ex_data;

    logic [31:0] rows_inst [rows];
    id_ex_t      rows_exp [rows];
    int          row_fill;
    logic [31:0] shadow [32];
    logic [31:0] rng;
    logic [31:0] bypass_data;
    id_ex_t      trace_exp [$];
    int          trace_at [$];
    int          bypass_at;
    int          redir_at;
    int          checks;
    int          value_errors;
    int          timing_errors;

    front_end_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .imem_wr  (imem_wr),
        .wb       (wb),
        .redirect (redirect),
        .ex_valid (ex_valid),
        .ex_data  (ex_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        for (int c = 0; c < timeout_cycles; c++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not end within %0d cycles", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input logic [5:0] funct);
        return {op_r_type, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input int target);
        return {op, target[25:0]};
    endfunction

    // flag bits from msb are alu_src_imm reg_write is_load mem_write is_branch branch_ne
    task automatic add_row(input logic [31:0] inst, input alu_op_e alu, input wb_sel_e sel,
                           input logic [5:0] flags, input logic [4:0] dest,
                           input logic [31:0] imm);
        id_ex_t e;
        e             = '0;
        e.alu_op      = alu;
        e.wb_sel      = sel;
        e.alu_src_imm = flags[5];
        e.reg_write   = flags[4];
        e.is_load     = flags[3];
        e.mem_write   = flags[2];
        e.is_branch   = flags[1];
        e.branch_ne   = flags[0];
        e.dest        = dest;
        e.imm         = imm;
        rows_inst[row_fill] = inst;
        rows_exp[row_fill]  = e;
        row_fill++;
    endtask

    task automatic fill_table();
        add_row(enc_r(1, 2, 3, fn_add), alu_add, wb_alu, 6'b010000, 5'd3, '0);
        add_row(enc_r(5, 6, 4, fn_sub), alu_sub, wb_alu, 6'b010000, 5'd4, '0);
        add_row(enc_r(8, 10, 7, fn_and), alu_and, wb_alu, 6'b010000, 5'd7, '0);
        add_row(enc_r(12, 13, 11, fn_or), alu_or, wb_alu, 6'b010000, 5'd11, '0);
        add_row(enc_r(15, 16, 14, fn_xor), alu_xor, wb_alu, 6'b010000, 5'd14, '0);
        add_row(enc_r(18, 19, 17, fn_nor), alu_nor, wb_alu, 6'b010000, 5'd17, '0);
        add_row(enc_r(21, 22, 20, fn_slt), alu_slt, wb_alu, 6'b010000, 5'd20, '0);
        add_row(enc_i(op_addi, 24, 23, 16'h8001), alu_add, wb_alu, 6'b110000, 5'd23, 32'hffff8001);
        add_row(enc_i(op_andi, 26, 25, 16'h8f0f), alu_and, wb_alu, 6'b110000, 5'd25, 32'h00008f0f);
        add_row(enc_i(op_ori, 28, 27, 16'hf00d), alu_or, wb_alu, 6'b110000, 5'd27, 32'h0000f00d);
        add_row(enc_i(op_slti, 30, 29, 16'hfffe), alu_slt, wb_alu, 6'b110000, 5'd29, 32'hfffffffe);
        add_row(enc_i(op_lcl, 0, 2, 16'hbeef), alu_pass, wb_alu, 6'b110000, 5'd2, 32'h0000beef);
        add_row(enc_i(op_lch, 0, 5, 16'h1234), alu_pass, wb_alu, 6'b110000, 5'd5, 32'h12340000);
        // load with a dependent add, then load with an independent sub
        add_row(enc_i(op_load, 1, 6, 16'h0010), alu_add, wb_mem, 6'b111000, 5'd6, 32'h00000010);
        add_row(enc_r(6, 2, 8, fn_add), alu_add, wb_alu, 6'b010000, 5'd8, '0);
        add_row(enc_i(op_load, 3, 10, 16'hfff0), alu_add, wb_mem, 6'b111000, 5'd10, 32'hfffffff0);
        add_row(enc_r(12, 13, 11, fn_sub), alu_sub, wb_alu, 6'b010000, 5'd11, '0);
        add_row(enc_i(op_store, 15, 14, 16'hfff4), alu_add, wb_alu, 6'b100100, 5'd0, 32'hfffffff4);
        add_row(enc_j(op_j, 20), alu_add, wb_alu, 6'b000000, 5'd0, '0);
        add_row(enc_r(1, 1, 1, fn_add), alu_add, wb_alu, 6'b010000, 5'd1, '0);
        add_row(enc_j(op_jal, 23), alu_add, wb_link, 6'b010000, 5'd31, '0);
        add_row(enc_r(2, 3, 4, fn_or), alu_or, wb_alu, 6'b010000, 5'd4, '0);
        add_row(enc_r(5, 6, 7, fn_xor), alu_xor, wb_alu, 6'b010000, 5'd7, '0);
        add_row(enc_i(op_addi, 17, 16, 16'h0005), alu_add, wb_alu, 6'b110000, 5'd16, 32'h5);
        add_row(enc_r(jr_reg, 0, 0, fn_jr), alu_add, wb_alu, 6'b000000, 5'd0, '0);
        add_row(enc_r(7, 8, 9, fn_xor), alu_xor, wb_alu, 6'b010000, 5'd9, '0);
        add_row(enc_i(op_beq, 1, 2, 16'hfffc), alu_sub, wb_alu, 6'b000010, 5'd0, 32'hfffffffc);
        add_row(enc_r(10, 11, 12, fn_and), alu_and, wb_alu, 6'b010000, 5'd12, '0);
        add_row(enc_r(13, 14, 15, fn_or), alu_or, wb_alu, 6'b010000, 5'd15, '0);
        add_row(enc_r(16, 17, 18, fn_nor), alu_nor, wb_alu, 6'b010000, 5'd18, '0);
        add_row(enc_i(op_bne, 3, 4, 16'h8002), alu_sub, wb_alu, 6'b000011, 5'd0, 32'hffff8002);
        add_row(enc_r(2, 3, 1, fn_slt), alu_slt, wb_alu, 6'b010000, 5'd1, '0);
    endtask

    // walk the program and note the cycle each output is due
    task automatic build_trace();
        int          pc;
        int          at;
        id_ex_t      e;
        logic [31:0] inst;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        pc = 0;
        at = 2;
        while (pc < rows) begin
            inst = rows_inst[pc];
            op   = inst[31:26];
            rs   = inst[25:21];
            rt   = inst[20:16];
            if (pc == bypass_row) begin
                shadow[rs] = bypass_data;
                bypass_at  = at;
            end
            e         = rows_exp[pc];
            e.pc_next = 8'(pc + 1);
            e.rs      = rs;
            e.rt      = rt;
            e.data_rs = shadow[rs];
            e.data_rt = shadow[rt];
            trace_exp.push_back(e);
            trace_at.push_back(at);
            if (op == op_j || op == op_jal) begin
                pc = int'(inst[pc_width-1:0]);
                at += 2;
            end else if (op == op_r_type && inst[5:0] == fn_jr) begin
                pc = int'(shadow[rs][pc_width-1:0]);
                at += 2;
            end else if (pc == redir_row) begin
                redir_at = at;
                pc = redir_addr;
                at += 3;
            end else begin
                // one bubble when the next instruction reads the loaded register
                if (op == op_load && pc + 1 < rows &&
                    (rows_inst[pc + 1][25:21] == rt || rows_inst[pc + 1][20:16] == rt)) begin
                    at += 1;
                end
                pc += 1;
                at += 1;
            end
        end
    endtask

    task automatic expect_idle(input string phase);
        checks++;
        assert (ex_valid === 1'b0) else begin
            timing_errors++;
            $display("[ERROR] %0t: unexpected valid output during %s, pc_next %0d",
                     $time, phase, ex_data.pc_next);
        end
    endtask

    initial begin
        int n;
        int k;
        int last_at;
        arst_n        = 1'b0;
        run           = 1'b0;
        imem_wr       = '0;
        wb            = '0;
        redirect      = '0;
        checks        = 0;
        value_errors  = 0;
        timing_errors = 0;
        row_fill      = 0;
        rng           = 32'h1a47c907;
        fill_table();
        repeat (10) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
        expect_idle("reset");

        for (int i = 0; i < rows; i++) begin
            imem_wr.en   = 1'b1;
            imem_wr.addr = 8'(i);
            imem_wr.data = rows_inst[i];
            @(posedge clk);
            #drive_delay;
            expect_idle("program load");
        end
        imem_wr = '0;

        // random register contents with the jr register pointing at its target
        for (int r = 0; r < 32; r++) begin
            rng       = xorshift32(rng);
            shadow[r] = (r == jr_reg) ? {rng[31:8], 8'(jr_target)} : rng;
            wb.en     = 1'b1;
            wb.addr   = 5'(r);
            wb.data   = shadow[r];
            @(posedge clk);
            #drive_delay;
            expect_idle("register preload");
        end
        wb  = '0;
        run = 1'b1;

        rng         = xorshift32(rng);
        bypass_data = rng;
        build_trace();
        last_at = trace_at[trace_at.size() - 1];

        n = 0;
        k = 0;
        while (n < last_at + 4) begin
            @(posedge clk);
            #drive_delay;
            n++;
            if (k < trace_at.size() && n == trace_at[k]) begin
                checks += 2;
                assert (ex_valid === 1'b1) else begin
                    timing_errors++;
                    $display("[ERROR] %0t: output %0d (pc_next %0d) missing at cycle %0d",
                             $time, k, trace_exp[k].pc_next, n);
                end
                assert (ex_data === trace_exp[k]) else begin
                    value_errors++;
                    $display("[ERROR] %0t: output %0d expected %h got %h",
                             $time, k, trace_exp[k], ex_data);
                end
                k++;
            end else begin
                expect_idle("run");
            end
            wb.en          = (n == bypass_at - 1);
            wb.addr        = rows_inst[bypass_row][25:21];
            wb.data        = bypass_data;
            redirect.taken = (n == redir_at);
            redirect.addr  = 8'(redir_addr);
            run            = (n < last_at - 1);
        end

        $display("checks: %0d, value errors: %0d, timing errors: %0d",
                 checks, value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/front_end_top.sv
// front end top: fetch, IF/ID, decode with register file and
// hazard unit, ID/EX
module front_end_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  core_pkg::imem_wr_t  imem_wr,
    input  core_pkg::wb_t       wb,
    input  core_pkg::redirect_t redirect,
    output logic                ex_valid,
    output core_pkg::id_ex_t    ex_data
);
    import core_pkg::*;

    logic                      fetch_valid;
    if_id_t                    fetch_data;
    logic                      id_valid;
    if_id_t                    id_data;
    logic                      dec_valid;
    id_ex_t                    dec_data;
    logic                      stall;
    logic                      jump;
    logic [pc_width-1:0]       jump_addr;
    logic [reg_addr_width-1:0] rs_addr;
    logic [reg_addr_width-1:0] rt_addr;
    logic [gpr_width-1:0]      data_rs;
    logic [gpr_width-1:0]      data_rt;
    logic                      if_id_flush;

    // the slot behind a jump or a taken branch is dropped
    assign if_id_flush = jump || redirect.taken;

    fetch_stage u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .imem_wr     (imem_wr),
        .stall       (stall),
        .jump        (jump),
        .jump_addr   (jump_addr),
        .redirect    (redirect),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk       (clk),
        .arst_n    (arst_n),
        .hold      (stall),
        .flush     (if_id_flush),
        .in_valid  (fetch_valid),
        .in_data   (fetch_data),
        .out_valid (id_valid),
        .out_data  (id_data)
    );

    decode_stage u_decode (
        .id_valid  (id_valid),
        .id_data   (id_data),
        .stall     (stall),
        .data_rs   (data_rs),
        .data_rt   (data_rt),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .jump      (jump),
        .jump_addr (jump_addr),
        .ex_valid  (dec_valid),
        .ex_data   (dec_data)
    );

    register_file u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb      (wb),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .data_rs (data_rs),
        .data_rt (data_rt)
    );

    hazard_unit u_hazard (
        .ex_valid   (ex_valid),
        .ex_is_load (ex_data.is_load),
        .ex_dest    (ex_data.dest),
        .id_valid   (id_valid),
        .id_inst    (id_data.instruction),
        .stall      (stall)
    );

    // no back-pressure downstream
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .arst_n    (arst_n),
        .hold      (1'b0),
        .flush     (redirect.taken),
        .in_valid  (dec_valid),
        .in_data   (dec_data),
        .out_valid (ex_valid),
        .out_data  (ex_data)
    );

endmodule

//--- hw/decode_stage.sv
// instruction decoder with immediate generation, destination select
// and jump resolution
module decode_stage (
    input  logic                                id_valid,
    input  core_pkg::if_id_t                    id_data,
    input  logic                                stall,
    input  logic [core_pkg::gpr_width-1:0]      data_rs,
    input  logic [core_pkg::gpr_width-1:0]      data_rt,
    output logic [core_pkg::reg_addr_width-1:0] rs_addr,
    output logic [core_pkg::reg_addr_width-1:0] rt_addr,
    output logic                                jump,
    output logic [core_pkg::pc_width-1:0]       jump_addr,
    output logic                                ex_valid,
    output core_pkg::id_ex_t                    ex_data
);
    import core_pkg::*;

    logic [5:0]                opcode;
    logic [5:0]                funct;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [15:0]               imm16;
    logic [25:0]               target;
    logic [gpr_width-1:0]      imm_sext;
    logic [gpr_width-1:0]      imm_zext;
    logic                      is_jr;
    logic                      is_jump;
    id_ex_t                    dec;

    assign opcode = id_data.instruction[31:26];
    assign rs     = id_data.instruction[25:21];
    assign rt     = id_data.instruction[20:16];
    assign rd     = id_data.instruction[15:11];
    assign funct  = id_data.instruction[5:0];
    assign imm16  = id_data.instruction[15:0];
    assign target = id_data.instruction[25:0];

    assign imm_sext = {{16{imm16[15]}}, imm16};
    assign imm_zext = {16'h0000, imm16};

    assign rs_addr = rs;
    assign rt_addr = rt;

    always_comb begin
        dec             = '0;
        dec.pc_next     = id_data.pc_next;
        dec.alu_op      = alu_add;
        dec.wb_sel      = wb_alu;
        dec.rs          = rs;
        dec.rt          = rt;
        dec.data_rs     = data_rs;
        dec.data_rt     = data_rt;

        // i-type arithmetic writes rt from the immediate
        if (opcode inside {op_addi, op_andi, op_ori, op_slti, op_lcl, op_lch, op_load}) begin
            dec.alu_src_imm = 1'b1;
            dec.reg_write   = 1'b1;
            dec.dest        = rt;
        end

        case (opcode)
            op_r_type: begin
                dec.reg_write = 1'b1;
                dec.dest      = rd;
                case (funct)
                    fn_add: dec.alu_op = alu_add;
                    fn_sub: dec.alu_op = alu_sub;
                    fn_and: dec.alu_op = alu_and;
                    fn_or:  dec.alu_op = alu_or;
                    fn_xor: dec.alu_op = alu_xor;
                    fn_nor: dec.alu_op = alu_nor;
                    fn_slt: dec.alu_op = alu_slt;
                    // jr and unknown functs write nothing
                    default: begin
                        dec.reg_write = 1'b0;
                        dec.dest      = '0;
                    end
                endcase
            end
            op_addi: dec.imm = imm_sext;
            op_andi: begin
                dec.alu_op = alu_and;
                dec.imm    = imm_zext;
            end
            op_ori: begin
                dec.alu_op = alu_or;
                dec.imm    = imm_zext;
            end
            op_slti: begin
                dec.alu_op = alu_slt;
                dec.imm    = imm_sext;
            end
            op_lcl: begin
                dec.alu_op = alu_pass;
                dec.imm    = imm_zext;
            end
            op_lch: begin
                dec.alu_op = alu_pass;
                dec.imm    = {imm16, 16'h0000};
            end
            op_load: begin
                dec.wb_sel  = wb_mem;
                dec.is_load = 1'b1;
                dec.imm     = imm_sext;
            end
            op_store: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
                dec.imm         = imm_sext;
            end
            // compare by subtraction downstream
            op_beq, op_bne: begin
                dec.alu_op    = alu_sub;
                dec.is_branch = 1'b1;
                dec.branch_ne = (opcode == op_bne);
                dec.imm       = imm_sext;
            end
            op_jal: begin
                dec.wb_sel    = wb_link;
                dec.reg_write = 1'b1;
                dec.dest      = link_reg;
            end
            default: ;
        endcase
    end

    // jumps resolve here, target taken from the low pc bits
    assign is_jr     = (opcode == op_r_type) && (funct == fn_jr);
    assign is_jump   = is_jr || (opcode == op_j) || (opcode == op_jal);
    assign jump      = id_valid && !stall && is_jump;
    assign jump_addr = is_jr ? data_rs[pc_width-1:0] : target[pc_width-1:0];

    // bubble while stalled
    assign ex_valid = id_valid && !stall;
    assign ex_data  = dec;

endmodule

//--- hw/hazard_unit.sv
// load-use hazard detection between ID/EX and IF/ID
module hazard_unit (
    input  logic                                ex_valid,
    input  logic                                ex_is_load,
    input  logic [core_pkg::reg_addr_width-1:0] ex_dest,
    input  logic                                id_valid,
    input  logic [core_pkg::inst_width-1:0]     id_inst,
    output logic                                stall
);
    import core_pkg::*;

    logic [reg_addr_width-1:0] id_rs;
    logic [reg_addr_width-1:0] id_rt;
    logic                      load_pending;
    logic                      uses_dest;

    assign id_rs = id_inst[25:21];
    assign id_rt = id_inst[20:16];

    // load still in flight ahead of decode
    assign load_pending = ex_valid && ex_is_load;

    // compared against both source fields, whatever the format
    assign uses_dest = (id_rs == ex_dest) || (id_rt == ex_dest);

    assign stall = load_pending && id_valid && uses_dest;

endmodule

//--- hw/register_file.sv
// general register file, two read ports, one write port with bypass
module register_file (
    input  logic                                clk,
    input  logic                                arst_n,
    input  core_pkg::wb_t                       wb,
    input  logic [core_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [core_pkg::reg_addr_width-1:0] rt_addr,
    output logic [core_pkg::gpr_width-1:0]      data_rs,
    output logic [core_pkg::gpr_width-1:0]      data_rt
);
    import core_pkg::*;

    logic [gpr_width-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // same-cycle write is seen by the read
    always_comb begin
        if (wb.en && (wb.addr == rs_addr)) begin
            data_rs = wb.data;
        end else begin
            data_rs = regs[rs_addr];
        end

        if (wb.en && (wb.addr == rt_addr)) begin
            data_rt = wb.data;
        end else begin
            data_rt = regs[rt_addr];
        end
    end

endmodule

//--- hw/fetch_stage.sv
// program counter, writable instruction memory and next pc selection
module fetch_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          run,
    input  core_pkg::imem_wr_t            imem_wr,
    input  logic                          stall,
    input  logic                          jump,
    input  logic [core_pkg::pc_width-1:0] jump_addr,
    input  core_pkg::redirect_t           redirect,
    output logic                          fetch_valid,
    output core_pkg::if_id_t              fetch_data
);
    import core_pkg::*;

    logic [inst_width-1:0] imem [imem_depth];
    logic [pc_width-1:0]   pc;
    logic [pc_width-1:0]   pc_inc;
    logic [pc_width-1:0]   pc_d;

    assign pc_inc = pc + 1'b1;

    // branch redirect, then jump, then stall, then increment
    always_comb begin
        if (redirect.taken) begin
            pc_d = redirect.addr;
        end else if (jump) begin
            pc_d = jump_addr;
        end else if (stall || !run) begin
            pc_d = pc;
        end else begin
            pc_d = pc_inc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_d;
        end
    end

    // load port
    always_ff @(posedge clk) begin
        if (imem_wr.en) begin
            imem[imem_wr.addr] <= imem_wr.data;
        end
    end

    // asynchronous read at the current pc
    assign fetch_data.instruction = imem[pc];
    assign fetch_data.pc_next     = pc_inc;
    assign fetch_valid            = run;

endmodule

//--- hw/pipe_reg.sv
// generic pipeline register with valid bit, hold and flush
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush beats hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

//--- hw/core_pkg.sv
// widths, opcode and funct encodings, enums and pipeline structs
// shared by the front end RTL
package core_pkg;

    // sizes
    localparam int pc_width       = 8;
    localparam int imem_depth     = 256;
    localparam int inst_width     = 32;
    localparam int gpr_width      = 32;
    localparam int reg_addr_width = 5;

    // jal writes its return address here
    localparam logic [reg_addr_width-1:0] link_reg = 5'd31;

    // major opcodes, inst[31:26]
    localparam logic [5:0] op_r_type = 6'h00;
    localparam logic [5:0] op_j      = 6'h01;
    localparam logic [5:0] op_jal    = 6'h02;
    localparam logic [5:0] op_load   = 6'h03;
    localparam logic [5:0] op_store  = 6'h04;
    localparam logic [5:0] op_beq    = 6'h05;
    localparam logic [5:0] op_bne    = 6'h06;
    localparam logic [5:0] op_addi   = 6'h09;
    localparam logic [5:0] op_andi   = 6'h0a;
    localparam logic [5:0] op_ori    = 6'h0b;
    localparam logic [5:0] op_slti   = 6'h0c;
    localparam logic [5:0] op_lcl    = 6'h0d;
    localparam logic [5:0] op_lch    = 6'h0e;

    // r-type funct codes, inst[5:0]
    localparam logic [5:0] fn_add = 6'h00;
    localparam logic [5:0] fn_sub = 6'h01;
    localparam logic [5:0] fn_and = 6'h02;
    localparam logic [5:0] fn_or  = 6'h03;
    localparam logic [5:0] fn_xor = 6'h05;
    localparam logic [5:0] fn_nor = 6'h06;
    localparam logic [5:0] fn_slt = 6'h0d;
    localparam logic [5:0] fn_jr  = 6'h0e;

    // execute stage operation
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_nor  = 3'd5,
        alu_slt  = 3'd6,
        alu_pass = 3'd7
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_mem  = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic [inst_width-1:0] instruction;
        logic [pc_width-1:0]   pc_next;
    } if_id_t;

    typedef struct packed {
        logic [pc_width-1:0]       pc_next;
        alu_op_e                   alu_op;
        logic                      alu_src_imm;
        wb_sel_e                   wb_sel;
        logic                      reg_write;
        logic [reg_addr_width-1:0] dest;
        logic                      is_load;
        logic                      mem_write;
        logic                      is_branch;
        logic                      branch_ne;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [gpr_width-1:0]      imm;
        logic [gpr_width-1:0]      data_rs;
        logic [gpr_width-1:0]      data_rt;
    } id_ex_t;

    // register write from the back end
    typedef struct packed {
        logic                      en;
        logic [reg_addr_width-1:0] addr;
        logic [gpr_width-1:0]      data;
    } wb_t;

    // resolved branch from the back end
    typedef struct packed {
        logic                taken;
        logic [pc_width-1:0] addr;
    } redirect_t;

    // instruction memory load port
    typedef struct packed {
        logic                  en;
        logic [pc_width-1:0]   addr;
        logic [inst_width-1:0] data;
    } imem_wr_t;

endpackage
